// ==== hw/ppu_pkg.sv ====
package ppu_pkg;

  // ========================================
  // Widths and basic types
  // ========================================

  localparam int color_width = 8;  // Bits per colour channel

  typedef struct packed {
    logic [color_width-1:0] r;  // Red sits in the top byte
    logic [color_width-1:0] g;
    logic [color_width-1:0] b;
  } rgb_t;

  typedef logic [4:0] scale_t;     // Scale factor code
  typedef logic [1:0] sl_thick_t;  // Scanline thickness

  // ========================================
  // Video mode encodings
  // ========================================

  typedef enum logic [2:0] {
    RES_480  = 3'd0,  // Also 576 lines at 50 Hz
    RES_720  = 3'd1,
    RES_960  = 3'd2,
    RES_1080 = 3'd3,
    RES_1200 = 3'd4
  } target_res_e;

  localparam int VM_50HZ_BIT = 3;  // Top bit of the mode code

  typedef enum logic [3:0] {
    VM_480P60  = 4'b0_000,  // Reset value
    VM_VGA60   = 4'b0_001,  // 640x480, 60 Hz only
    VM_720P60  = 4'b0_010,
    VM_960P60  = 4'b0_011,
    VM_1080P60 = 4'b0_100,
    VM_1200P60 = 4'b0_101,
    VM_576P50  = 4'b1_000,
    VM_720P50  = 4'b1_010,
    VM_960P50  = 4'b1_011,
    VM_1080P50 = 4'b1_100,
    VM_1200P50 = 4'b1_101
  } videomode_e;

  // ========================================
  // 43-bit configuration word
  // ========================================

  typedef struct packed {
    target_res_e target_res;   // Output resolution
    logic        use_vga_480p; // VGA timing instead of 480p
    logic        force60;
    logic        force50;
    logic        lowlatency;   // Forcing not allowed here
    scale_t      vscale;
    scale_t      hscale;
    logic        link_hv_scale;
    logic        limited_rgb;  // 16..235 output range
    logic [3:0]  sl240_str;    // 240p scanline profile
    logic [4:0]  sl240_hyb;
    logic        sl240_en;
    logic        sl240_id;
    logic        sl240_method;
    logic        sl480_linked; // 480i reuses the 240p profile
    logic [3:0]  sl480_str;    // 480i scanline profile
    logic [4:0]  sl480_hyb;
    logic        sl480_en;
    logic        sl480_id;
  } cfg_word_t;

  // ========================================
  // Thresholds and pipeline constants
  // ========================================

  localparam scale_t SL_THICK_LIM1 = 5'd6;   // Below 3.5x
  localparam scale_t SL_THICK_LIM2 = 5'd14;  // Below 5.5x

  localparam logic [color_width-1:0] LIMIT_COEFF  = 8'd220;  // 235 - 16 + 1
  localparam logic [color_width-1:0] LIMIT_OFFSET = 8'd16;   // Black level

  localparam int OUT_PIPE_STAGES = 3;  // Output pipeline depth
  localparam int SYNC_STAGES     = 2;  // Flops per synchroniser bit

endpackage

// ==== hw/cfg_sync.sv ====
`timescale 1ns/1ns

module cfg_sync #(
  parameter type payload_t = logic
) (
  input  logic     VCLK_Tx,
  input  logic     nVRST_Tx,
  input  payload_t data_i,  // Asynchronous level
  output payload_t data_o
);

  import ppu_pkg::*;

  payload_t sync_q [SYNC_STAGES];  // Flop chain starting at index 0

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= data_i;  // May go metastable
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign data_o = sync_q[SYNC_STAGES-1];

  // Any new output value is exactly what was sampled SYNC_STAGES edges ago
  a_sync_delay: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    !$stable(data_o) |-> (data_o == $past(data_i, SYNC_STAGES))
  );

endmodule

// ==== hw/videomode_select.sv ====
`timescale 1ns/1ns

module videomode_select (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  ppu_pkg::cfg_word_t cfg_i,      // Synced configuration
  input  logic               palmode_i,  // Synced PAL flag
  output ppu_pkg::videomode_e videomode_o,
  output ppu_pkg::scale_t    hscale_o,
  output ppu_pkg::scale_t    vscale_o
);

  import ppu_pkg::*;

  logic       use_50hz;
  videomode_e mode_d;

  // ========================================
  // 50/60 Hz decision
  // ========================================

  // Low-latency mode follows the input rate, so forcing is ignored there
  always_comb begin
    if (cfg_i.force60 && !cfg_i.lowlatency) begin
      use_50hz = 1'b0;
    end else if (cfg_i.force50 && !cfg_i.lowlatency) begin
      use_50hz = 1'b1;
    end else begin
      use_50hz = palmode_i;  // Native input rate
    end
  end

  // ========================================
  // Resolution to mode table
  // ========================================

  always_comb begin
    case (cfg_i.target_res)
      RES_720:  mode_d = use_50hz ? VM_720P50  : VM_720P60;
      RES_960:  mode_d = use_50hz ? VM_960P50  : VM_960P60;
      RES_1080: mode_d = use_50hz ? VM_1080P50 : VM_1080P60;
      RES_1200: mode_d = use_50hz ? VM_1200P50 : VM_1200P60;
      default: begin  // RES_480 and unused codes
        if (use_50hz) begin
          mode_d = VM_576P50;  // No VGA variant at 50 Hz
        end else if (cfg_i.use_vga_480p) begin
          mode_d = VM_VGA60;
        end else begin
          mode_d = VM_480P60;
        end
      end
    endcase
  end

  // Output registers
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      videomode_o <= VM_480P60;
      hscale_o    <= '0;
      vscale_o    <= '0;
    end else begin
      videomode_o <= mode_d;
      vscale_o    <= cfg_i.vscale;
      // H follows V when the scales are linked
      hscale_o    <= cfg_i.link_hv_scale ? cfg_i.vscale : cfg_i.hscale;
    end
  end

  // VGA timing code never carries the 50 Hz flag
  a_vga_60_only: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (videomode_o[VM_50HZ_BIT-1:0] == VM_VGA60[VM_50HZ_BIT-1:0])
      |-> !videomode_o[VM_50HZ_BIT]
  );

endmodule

// ==== hw/scanline_cfg.sv ====
`timescale 1ns/1ns

module scanline_cfg (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  ppu_pkg::cfg_word_t cfg_i,       // Synced configuration
  input  logic               n64_480i_i,  // Synced interlace flag
  output ppu_pkg::sl_thick_t sl_thickness_o,
  output logic [7:0]         sl_str_o,
  output logic [4:0]         sl_hyb_str_o,
  output logic               sl_id_o,
  output logic               sl_en_o,
  output logic               sl_method_o
);

  import ppu_pkg::*;

  logic [3:0] str_sel;     // 4-bit strength before expansion
  logic [4:0] hyb_sel;
  logic       id_sel;
  logic       en_sel;
  logic       method_sel;
  sl_thick_t  thick_d;

  // ========================================
  // Profile selection
  // ========================================

  always_comb begin
    if (!n64_480i_i) begin  // 240p input
      str_sel    = cfg_i.sl240_str;
      hyb_sel    = cfg_i.sl240_hyb;
      id_sel     = cfg_i.sl240_id;
      en_sel     = cfg_i.sl240_en;
      method_sel = cfg_i.sl240_method;
    end else begin
      en_sel     = cfg_i.sl480_en;  // Enable is never linked
      method_sel = 1'b0;            // Only one method in 480i
      if (cfg_i.sl480_linked) begin
        str_sel = cfg_i.sl240_str;
        hyb_sel = cfg_i.sl240_hyb;
        id_sel  = cfg_i.sl240_id;
      end else begin
        str_sel = cfg_i.sl480_str;
        hyb_sel = cfg_i.sl480_hyb;
        id_sel  = cfg_i.sl480_id;
      end
    end
  end

  // Thicker lines for larger vertical scale
  always_comb begin
    if (cfg_i.vscale < SL_THICK_LIM1) begin
      thick_d = 2'd0;
    end else if (cfg_i.vscale < SL_THICK_LIM2) begin
      thick_d = 2'd1;
    end else begin
      thick_d = 2'd2;
    end
  end

  // Output registers
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      sl_thickness_o <= '0;
      sl_str_o       <= '0;
      sl_hyb_str_o   <= '0;
      sl_id_o        <= 1'b0;
      sl_en_o        <= 1'b0;
      sl_method_o    <= 1'b0;
    end else begin
      sl_thickness_o <= thick_d;
      sl_str_o       <= {str_sel, 4'hF};  // ((s+1)*16)-1 equals s*16+15
      sl_hyb_str_o   <= hyb_sel;
      sl_id_o        <= id_sel;
      sl_en_o        <= en_sel;
      sl_method_o    <= method_sel;
    end
  end

endmodule

// ==== hw/rgb_range_limit.sv ====
`timescale 1ns/1ns

module rgb_range_limit (
  input  logic          VCLK_Tx,
  input  logic          nVRST_Tx,
  input  logic          limited_rgb_i,  // Synced mode bit
  input  logic          hsync_i,
  input  logic          vsync_i,
  input  logic          de_i,
  input  ppu_pkg::rgb_t vdata_i,
  output logic          hsync_o,
  output logic          vsync_o,
  output logic          de_o,
  output ppu_pkg::rgb_t vdata_o
);

  import ppu_pkg::*;

  // Channel 2 is red and channel 0 is blue
  logic [2:0][color_width-1:0] din;
  logic [2:0][color_width-1:0] vout;
  logic [2:0][color_width-1:0] full_q [OUT_PIPE_STAGES-1];  // Full-range delay

  logic [OUT_PIPE_STAGES-1:0] hs_q;
  logic [OUT_PIPE_STAGES-1:0] vs_q;
  logic [OUT_PIPE_STAGES-1:0] de_q;

  assign din = vdata_i;

  // ========================================
  // Sync and full-range delay lines
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      hs_q <= '0;
      vs_q <= '0;
      de_q <= '0;
      for (int i = 0; i < OUT_PIPE_STAGES-1; i++) begin
        full_q[i] <= '0;
      end
    end else begin
      hs_q <= {hs_q[OUT_PIPE_STAGES-2:0], hsync_i};
      vs_q <= {vs_q[OUT_PIPE_STAGES-2:0], vsync_i};
      de_q <= {de_q[OUT_PIPE_STAGES-2:0], de_i};
      full_q[0] <= din;
      for (int i = 1; i < OUT_PIPE_STAGES-1; i++) begin
        full_q[i] <= full_q[i-1];
      end
    end
  end

  assign hsync_o = hs_q[OUT_PIPE_STAGES-1];
  assign vsync_o = vs_q[OUT_PIPE_STAGES-1];
  assign de_o    = de_q[OUT_PIPE_STAGES-1];

  // ========================================
  // Per-channel range compression
  // ========================================

  for (genvar c = 0; c < 3; c++) begin : g_chan
    logic [2*color_width-1:0] prod;     // c * 220
    logic [color_width:0]     lim_q;    // Stage 1 product over 128
    logic [color_width-1:0]   lim_rnd;  // Stage 2 rounded product over 256

    assign prod = din[c] * LIMIT_COEFF;

    always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
      if (!nVRST_Tx) begin
        lim_q   <= '0;
        lim_rnd <= '0;
        vout[c] <= '0;
      end else begin
        lim_q   <= prod[2*color_width-1 -: color_width+1];          // Truncate
        lim_rnd <= lim_q[color_width:1] + {{(color_width-1){1'b0}}, lim_q[0]};  // Round half up
        if (limited_rgb_i) begin
          vout[c] <= lim_rnd + LIMIT_OFFSET;  // Lift black to 16
        end else begin
          vout[c] <= full_q[OUT_PIPE_STAGES-2][c];
        end
      end
    end

    // Held limited mode keeps every channel inside 16..235
    a_limited_range: assert property (
      @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      (limited_rgb_i [*OUT_PIPE_STAGES]) |=>
        ((vout[c] >= LIMIT_OFFSET) && (vout[c] <= LIMIT_OFFSET + LIMIT_COEFF - 1'b1))
    );
  end

  assign vdata_o = vout;

endmodule

// ==== hw/ppu_tx_top.sv ====
`timescale 1ns/1ns

module ppu_tx_top (
  input  logic                VCLK_Tx,
  input  logic                nVRST_Tx,
  // Asynchronous configuration and video info
  input  ppu_pkg::cfg_word_t  cfg_i,
  input  logic                palmode_i,
  input  logic                n64_480i_i,
  // Scaler output stream
  input  logic                hsync_i,
  input  logic                vsync_i,
  input  logic                de_i,
  input  ppu_pkg::rgb_t       vdata_i,
  // Video towards the transmitter
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                de_o,
  output ppu_pkg::rgb_t       vdata_o,
  // Decoded status
  output ppu_pkg::videomode_e videomode_o,
  output ppu_pkg::scale_t     hscale_o,
  output ppu_pkg::scale_t     vscale_o,
  output ppu_pkg::sl_thick_t  sl_thickness_o,
  output logic [7:0]          sl_str_o,
  output logic [4:0]          sl_hyb_str_o,
  output logic                sl_id_o,
  output logic                sl_en_o,
  output logic                sl_method_o
);

  import ppu_pkg::*;

  cfg_word_t  cfg_synced;
  logic [1:0] vinfo_synced;  // {PAL, 480i}

  // ========================================
  // Resync into VCLK_Tx
  // ========================================

  cfg_sync #(
    .payload_t (cfg_word_t)
  ) u_cfg_sync (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .data_i   (cfg_i),
    .data_o   (cfg_synced)
  );

  cfg_sync #(
    .payload_t (logic [1:0])
  ) u_vinfo_sync (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .data_i   ({palmode_i, n64_480i_i}),
    .data_o   (vinfo_synced)
  );

  // Status decoders
  videomode_select u_videomode_select (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .cfg_i       (cfg_synced),
    .palmode_i   (vinfo_synced[1]),
    .videomode_o (videomode_o),
    .hscale_o    (hscale_o),
    .vscale_o    (vscale_o)
  );

  scanline_cfg u_scanline_cfg (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .cfg_i          (cfg_synced),
    .n64_480i_i     (vinfo_synced[0]),
    .sl_thickness_o (sl_thickness_o),
    .sl_str_o       (sl_str_o),
    .sl_hyb_str_o   (sl_hyb_str_o),
    .sl_id_o        (sl_id_o),
    .sl_en_o        (sl_en_o),
    .sl_method_o    (sl_method_o)
  );

  // Final output pipeline
  rgb_range_limit u_rgb_range_limit (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .limited_rgb_i (cfg_synced.limited_rgb),
    .hsync_i       (hsync_i),
    .vsync_i       (vsync_i),
    .de_i          (de_i),
    .vdata_i       (vdata_i),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .de_o          (de_o),
    .vdata_o       (vdata_o)
  );

endmodule

// ==== sim/ppu_tx_tb.sv ====
`timescale 1ns/1ns

module ppu_tx_tb;

  import ppu_pkg::*;

  localparam int NUM_COLS   = 30;   // Numbers per stimulus line
  localparam int STREAM_LEN = 200;  // Pixels per video phase

  logic          VCLK_Tx = 1'b0;
  logic          nVRST_Tx;
  cfg_word_t     cfg_i;
  logic          palmode_i;
  logic          n64_480i_i;
  logic          hsync_i;
  logic          vsync_i;
  logic          de_i;
  rgb_t          vdata_i;
  logic          hsync_o;
  logic          vsync_o;
  logic          de_o;
  rgb_t          vdata_o;
  videomode_e    videomode_o;
  scale_t        hscale_o;
  scale_t        vscale_o;
  sl_thick_t     sl_thickness_o;
  logic [7:0]    sl_str_o;
  logic [4:0]    sl_hyb_str_o;
  logic          sl_id_o;
  logic          sl_en_o;
  logic          sl_method_o;

  int            fields[$];              // All numbers of the stimulus file
  logic [26:0]   px_q[$];                // {hsync, vsync, de, rgb} in flight
  logic [15:0]   lfsr_state = 16'd57;
  int            cycles = 0;
  int            cycle_limit = 2000;     // Raised once the file is read
  int            check_count = 0;
  int            err_count = 0;
  int            other_count = 0;

  ppu_tx_top dut0 (.*);

  always #50 VCLK_Tx = ~VCLK_Tx;  // 100 ns period

  // ========================================
  // Helpers
  // ========================================

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[0];
    s  = s >> 1;
    if (fb) s = s ^ 16'hB400;  // Galois taps 16,14,13,11
    return s;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Multiply by 220, keep bits 15..7, round, add 16
  function automatic logic [7:0] limit_channel(input logic [7:0] c);
    logic [15:0] p;
    logic [8:0]  q;
    logic [8:0]  r;
    p = c * 16'd220;
    q = p[15:7];
    r = (q >> 1) + q[0];
    return r[7:0] + 8'd16;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic tick();
    @(posedge VCLK_Tx);
    #10;  // Drive and sample away from the edge
  endtask

  task automatic report_counts();
    $display("Checks %0d, value errors %0d, other errors %0d",
             check_count, err_count, other_count);
  endtask

  // ========================================
  // Configuration cases
  // ========================================

  task automatic apply_case(input int b);
    cfg_i.target_res    = target_res_e'(fields[b]);
    cfg_i.use_vga_480p  = fields[b+1];
    cfg_i.force60       = fields[b+2];
    cfg_i.force50       = fields[b+3];
    cfg_i.lowlatency    = fields[b+4];
    cfg_i.vscale        = fields[b+5];
    cfg_i.hscale        = fields[b+6];
    cfg_i.link_hv_scale = fields[b+7];
    cfg_i.limited_rgb   = fields[b+8];
    cfg_i.sl240_str     = fields[b+9];   // 240p profile
    cfg_i.sl240_hyb     = fields[b+10];
    cfg_i.sl240_en      = fields[b+11];
    cfg_i.sl240_id      = fields[b+12];
    cfg_i.sl240_method  = fields[b+13];
    cfg_i.sl480_linked  = fields[b+14];  // 480i profile
    cfg_i.sl480_str     = fields[b+15];
    cfg_i.sl480_hyb     = fields[b+16];
    cfg_i.sl480_en      = fields[b+17];
    cfg_i.sl480_id      = fields[b+18];
    palmode_i           = fields[b+19];
    n64_480i_i          = fields[b+20];
  endtask

  task automatic check_status(input int b);
    check_value("videomode_o", fields[b+21], videomode_o);
    check_value("hscale_o", fields[b+22], hscale_o);
    check_value("vscale_o", fields[b+23], vscale_o);
    check_value("sl_thickness_o", fields[b+24], sl_thickness_o);
    check_value("sl_str_o", fields[b+25], sl_str_o);
    check_value("sl_hyb_str_o", fields[b+26], sl_hyb_str_o);
    check_value("sl_id_o", fields[b+27], sl_id_o);
    check_value("sl_en_o", fields[b+28], sl_en_o);
    check_value("sl_method_o", fields[b+29], sl_method_o);
  endtask

  // ========================================
  // Video stream against a 3-deep model
  // ========================================

  task automatic run_stream(input logic limited);
    logic [31:0] r;
    logic [26:0] exp_px;
    logic [23:0] exp_rgb;
    hsync_i = 1'b0;
    vsync_i = 1'b0;
    de_i    = 1'b0;
    vdata_i = '0;
    repeat (8) tick();  // Let the mode bit settle
    px_q.delete();
    repeat (3) px_q.push_back('0);  // Idle samples already in the pipe
    for (int n = 0; n < STREAM_LEN; n++) begin
      tick();
      exp_px  = px_q.pop_front();
      exp_rgb = exp_px[23:0];
      if (limited) begin
        exp_rgb = {limit_channel(exp_rgb[23:16]), limit_channel(exp_rgb[15:8]),
                   limit_channel(exp_rgb[7:0])};
      end
      check_value("hsync_o", exp_px[26], hsync_o);
      check_value("vsync_o", exp_px[25], vsync_o);
      check_value("de_o", exp_px[24], de_o);
      check_value("vdata_o", exp_rgb, vdata_o);
      take_bits(1, r);
      hsync_i = r[0];
      take_bits(1, r);
      vsync_i = r[0];
      take_bits(1, r);
      de_i = r[0];
      take_bits(24, r);
      vdata_i = r[23:0];
      if (n == 0) vdata_i = 24'h000000;       // Black end of the range
      else if (n == 1) vdata_i = 24'hFFFFFF;  // White end
      px_q.push_back({hsync_i, vsync_i, de_i, vdata_i});
    end
  endtask

  // Watchdog
  always @(posedge VCLK_Tx) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the run did not reach its end", cycles);
      report_counts();
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int    fd;
    int    code;
    int    v;
    int    num_cases;
    string line;
    nVRST_Tx   = 1'b0;
    cfg_i      = '0;
    palmode_i  = 1'b0;
    n64_480i_i = 1'b0;
    hsync_i    = 1'b0;
    vsync_i    = 1'b0;
    de_i       = 1'b0;
    vdata_i    = '0;

    fd = $fopen("sim/ppu_tx_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file sim/ppu_tx_stimulus.txt");
      other_count++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%d", v);
        if (code == 1) fields.push_back(v);
        else code = $fgets(line, fd);  // Skip comment text
      end
      $fclose(fd);
    end
    if (fields.size() % NUM_COLS != 0) begin
      $display("Stimulus file has a line with a wrong number of columns");
      other_count++;
    end
    num_cases = fields.size() / NUM_COLS;
    if (num_cases == 0) begin
      $display("Stimulus file holds no configuration cases");
      other_count++;
    end
    cycle_limit = 40 * num_cases + 2000;

    // Reset values while reset is still low
    repeat (5) tick();
    check_value("de_o", 0, de_o);
    check_value("hsync_o", 0, hsync_o);
    check_value("vsync_o", 0, vsync_o);
    check_value("vdata_o", 0, vdata_o);
    check_value("videomode_o", VM_480P60, videomode_o);
    check_value("sl_en_o", 0, sl_en_o);
    check_value("hscale_o", 0, hscale_o);
    nVRST_Tx = 1'b1;

    for (int k = 0; k < num_cases; k++) begin
      apply_case(k * NUM_COLS);
      repeat (8) tick();
      check_status(k * NUM_COLS);
    end

    cfg_i.limited_rgb = 1'b0;  // Full range first
    run_stream(1'b0);
    cfg_i.limited_rgb = 1'b1;
    run_stream(1'b1);

    report_counts();
    if (err_count == 0 && other_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim/ppu_tx_stimulus.txt ====
# res vga f60 f50 ll vscale hscale link lim | 240p str hyb en id method | 480i link str hyb en id
# pal 480i | expected mode hscale vscale thick str hyb id en method (mode 8..13 are 50 Hz)
0 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 0   0 3 4 0 95 10 0 1 1
0 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   1 0   8 3 4 0 95 10 0 1 1
0 1 0 0 0  4 3 0 1   5 10 1 0 1  0 9 20 0 1   0 0   1 3 4 0 95 10 0 1 1
0 1 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   1 0   8 3 4 0 95 10 0 1 1
1 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 0   2 3 4 0 95 10 0 1 1
1 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   1 0  10 3 4 0 95 10 0 1 1
2 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 0   3 3 4 0 95 10 0 1 1
2 0 0 0 0  4 3 0 1   5 10 1 0 1  0 9 20 0 1   1 0  11 3 4 0 95 10 0 1 1
3 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 0   4 3 4 0 95 10 0 1 1
3 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   1 0  12 3 4 0 95 10 0 1 1
4 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 0   5 3 4 0 95 10 0 1 1
4 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   1 0  13 3 4 0 95 10 0 1 1
3 0 1 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   1 0   4 3 4 0 95 10 0 1 1
2 0 0 1 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 0  11 3 4 0 95 10 0 1 1
1 0 1 1 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   1 0   2 3 4 0 95 10 0 1 1
1 0 0 1 1  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 0   2 3 4 0 95 10 0 1 1
4 0 1 0 1  4 3 0 0   5 10 1 0 1  0 9 20 0 1   1 0  13 3 4 0 95 10 0 1 1
0 1 0 1 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 0   8 3 4 0 95 10 0 1 1
0 0 0 0 0  5 9 0 0   5 10 1 0 1  0 9 20 0 1   0 0   0 9 5 0 95 10 0 1 1
0 0 0 0 0  6 9 1 0   5 10 1 0 1  0 9 20 0 1   0 0   0 6 6 1 95 10 0 1 1
0 0 0 0 0 13 2 0 1   5 10 1 0 1  0 9 20 0 1   0 0   0 2 13 1 95 10 0 1 1
0 0 0 0 0 14 2 1 0   5 10 1 0 1  0 9 20 0 1   0 0   0 14 14 2 95 10 0 1 1
0 0 0 0 0  4 3 0 0   5 10 1 0 1  0 9 20 0 1   0 1   0 3 4 0 159 20 1 0 0
0 0 0 0 0  4 3 0 0   5 10 1 0 1  1 9 20 0 1   0 1   0 3 4 0 95 10 0 0 0
0 0 0 0 0  4 3 0 0  15 31 0 1 0  0 9 20 0 1   0 0   0 3 4 0 255 31 1 0 0
0 0 0 0 0  4 3 0 0   0 0 1 1 1   0 9 20 0 1   0 0   0 3 4 0 15 0 1 1 1
2 0 0 0 0  4 3 0 0   5 10 1 0 1  0 12 7 1 0   1 1  11 3 4 0 207 7 0 1 0

// ==== files.f ====
hw/ppu_pkg.sv
hw/cfg_sync.sv
hw/videomode_select.sv
hw/scanline_cfg.sv
hw/rgb_range_limit.sv
hw/ppu_tx_top.sv
sim/ppu_tx_tb.sv

// ==== Bender.yml ====
package:
  name: ppu_tx

sources:
  - files:
      - hw/ppu_pkg.sv
      - hw/cfg_sync.sv
      - hw/videomode_select.sv
      - hw/scanline_cfg.sv
      - hw/rgb_range_limit.sv
      - hw/ppu_tx_top.sv
  - target: simulation
    files:
      - sim/ppu_tx_tb.sv
